/* logic/periph_spi_mux.sv */
//////////////////////////////
// routes host SPI to one of eight peripheral ports
// port chosen by periph_sel and active while ss2_n is low
//////////////////////////////

module periph_spi_mux
  import spi_bank_pkg::*;
(
  input  logic [N_PERIPH-1:0] periph_sel,
  input  logic                ss2_n,
  input  spi_pins_t           spi_in,
  input  logic                bank_miso,
  input  logic [N_PERIPH-1:0] periph_miso,
  output periph_bus_t         periph,
  output logic                miso
);

  // one hot decode where value n picks port n-1 and 0 picks none
  logic [N_PERIPH-1:0] sel_line;
  // decode gated by ss2_n
  logic [N_PERIPH-1:0] act_line;

  always_comb
  begin
    for (int i = 0; i < N_PERIPH; i++)
      sel_line[i] = (periph_sel == 8'(i + 1));
  end

  assign act_line = sel_line & {N_PERIPH{~ss2_n}};

  //////////////////////////////
  // outgoing lines
  //////////////////////////////

  // inverted for active low ports and passed for strobe ports
  // idle level comes out as high or low per port accordingly
  assign periph.ss = act_line ^ ~PERIPH_CS_POL;

  // unselected ports held low
  assign periph.sclk = act_line & {N_PERIPH{spi_in.sclk}};
  assign periph.mosi = act_line & {N_PERIPH{spi_in.mosi}};

  //////////////////////////////
  // miso return
  //////////////////////////////

  // bank owns miso unless ss2_n is asserted
  assign miso = ss2_n ? bank_miso : |(periph_miso & act_line);

endmodule

/* logic/reg_bank.sv */
//////////////////////////////
// control register bank
// applies frames from the receiver on req/ack
// and serves the read byte for the addressed register
//////////////////////////////

module reg_bank
  import spi_bank_pkg::*;
(
  input  logic       cs,
  input  logic       rst_n,
  input  frame_t     frame,
  input  logic       frame_req,
  input  logic [7:0] rd_addr,
  output logic       frame_ack,
  output logic [7:0] rd_data,
  output ctrl_regs_t regs
);

  //////////////////////////////
  // set/clear/toggle rule
  //////////////////////////////

  // data[3:0] set bits, data[7:4] clear bits
  // overlap means toggle exactly those bits and nothing else
  function automatic logic [CTRL_W-1:0] upd_ctrl(
    input logic [CTRL_W-1:0] cur,
    input logic [7:0]        data
  );
    logic [CTRL_W-1:0] set_b;
    logic [CTRL_W-1:0] clr_b;
    logic [CTRL_W-1:0] both;
    set_b = data[CTRL_W-1:0];
    clr_b = data[2*CTRL_W-1:CTRL_W];
    both  = set_b & clr_b;
    if (|both)
      upd_ctrl = cur ^ both;
    else
      upd_ctrl = (cur | set_b) & ~clr_b;
  endfunction

  //////////////////////////////
  // frame apply and ack
  //////////////////////////////

  // new request not yet acknowledged
  logic take;

  assign take = frame_req && !frame_ack;

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      regs.led        <= LED_RESET;
      regs.periph_sel <= '0;
      regs.oe_4094    <= '0;
      regs.adc        <= '0;
      frame_ack       <= 1'b0;
    end
    else
    begin
      // ack follows req one cycle later in both directions
      if (take)
        frame_ack <= 1'b1;
      else if (!frame_req)
        frame_ack <= 1'b0;

      if (take)
      begin
        case (frame.addr)
          ADDR_LED:
            regs.led <= upd_ctrl(regs.led, frame.data);
          // mux select is a plain byte load
          ADDR_PERIPH_SEL:
            regs.periph_sel <= frame.data;
          ADDR_OE_4094:
            regs.oe_4094 <= upd_ctrl(regs.oe_4094, frame.data);
          ADDR_ADC:
            regs.adc <= upd_ctrl(regs.adc, frame.data);
          // soft reset clears everything
          ADDR_SOFT_RESET:
          begin
            regs.led        <= '0;
            regs.periph_sel <= '0;
            regs.oe_4094    <= '0;
            regs.adc        <= '0;
          end
          // power-up leaves routing and 4094 enable alone
          ADDR_POWERUP:
          begin
            regs.led <= '0;
            regs.adc <= '0;
          end
          // unknown address has no effect
          default:
          begin
          end
        endcase
      end
    end
  end

  //////////////////////////////
  // read mux
  //////////////////////////////

  // right aligned and zero extended
  always_comb
  begin
    case (rd_addr)
      ADDR_LED:        rd_data = {4'b0000, regs.led};
      ADDR_PERIPH_SEL: rd_data = regs.periph_sel;
      ADDR_OE_4094:    rd_data = {4'b0000, regs.oe_4094};
      ADDR_ADC:        rd_data = {4'b0000, regs.adc};
      default:         rd_data = 8'h00;
    endcase
  end

  // receiver keeps req up until it has seen the ack
  assert property (@(posedge cs) disable iff (!rst_n)
    $rose(frame_ack) |-> frame_req)
    else $error("frame_ack raised while frame_req is low");

endmodule

/* logic/spi_bank_pkg.sv */
//////////////////////////////
// shared definitions for the SPI control register bank
// addresses, widths, chip select polarity and the bus structs
// imported by every RTL module of the subsystem
//////////////////////////////

package spi_bank_pkg;

  //////////////////////////////
  // register addresses
  //////////////////////////////

  // plain set/clear/toggle registers
  localparam logic [7:0] ADDR_LED        = 8'd7;
  localparam logic [7:0] ADDR_PERIPH_SEL = 8'd8;
  localparam logic [7:0] ADDR_OE_4094    = 8'd9;
  localparam logic [7:0] ADDR_ADC        = 8'd14;

  // command addresses, data byte ignored
  localparam logic [7:0] ADDR_SOFT_RESET = 8'd11;
  localparam logic [7:0] ADDR_POWERUP    = 8'd6;

  //////////////////////////////
  // sizes and constants
  //////////////////////////////

  // address byte plus data byte
  localparam int FRAME_BITS = 16;

  // set/clear register width, data byte splits into set and clear halves
  localparam int CTRL_W = 4;

  // downstream peripheral SPI ports
  localparam int N_PERIPH = 8;

  // 1 = active high strobe (4094 style), 0 = normal active low ss
  localparam logic [N_PERIPH-1:0] PERIPH_CS_POL = 8'b0111_0000;

  // led comes up with bit 0 lit
  localparam logic [CTRL_W-1:0] LED_RESET = 4'b0001;

  //////////////////////////////
  // structs
  //////////////////////////////

  // host SPI inputs, raw from the pins
  typedef struct packed {
    logic sclk;
    logic ss_n;
    logic mosi;
  } spi_pins_t;

  // finished frame, receiver to bank
  typedef struct packed {
    logic [7:0] addr;
    logic [7:0] data;
  } frame_t;

  // current register contents
  typedef struct packed {
    logic [CTRL_W-1:0]   led;
    logic [N_PERIPH-1:0] periph_sel;
    logic [CTRL_W-1:0]   oe_4094;
    logic [CTRL_W-1:0]   adc;
  } ctrl_regs_t;

  // outgoing peripheral SPI lines, one bit per port
  typedef struct packed {
    logic [N_PERIPH-1:0] ss;
    logic [N_PERIPH-1:0] sclk;
    logic [N_PERIPH-1:0] mosi;
  } periph_bus_t;

endpackage

/* logic/spi_bank_top.sv */
//////////////////////////////
// SPI control register subsystem, top level
// frame receiver, register bank and peripheral mux
//////////////////////////////

module spi_bank_top
  import spi_bank_pkg::*;
(
  input  logic                cs,
  input  logic                rst_n,
  input  spi_pins_t           spi_in,
  input  logic                ss2_n,
  input  logic [N_PERIPH-1:0] periph_miso,
  output logic                miso,
  output periph_bus_t         periph,
  output logic [CTRL_W-1:0]   led,
  output logic [CTRL_W-1:0]   oe_4094,
  output logic [CTRL_W-1:0]   adc_ctl
);

  // receiver to bank
  frame_t     frame;
  logic       frame_req;
  logic       frame_ack;
  logic [7:0] rd_addr;
  logic [7:0] rd_data;

  // bank outputs and receiver miso
  ctrl_regs_t regs;
  logic       bank_miso;

  spi_frame_rx u_rx (
    .cs        (cs),
    .rst_n     (rst_n),
    .spi_in    (spi_in),
    .rd_data   (rd_data),
    .frame_ack (frame_ack),
    .rd_addr   (rd_addr),
    .frame     (frame),
    .frame_req (frame_req),
    .bank_miso (bank_miso)
  );

  reg_bank u_bank (
    .cs        (cs),
    .rst_n     (rst_n),
    .frame     (frame),
    .frame_req (frame_req),
    .rd_addr   (rd_addr),
    .frame_ack (frame_ack),
    .rd_data   (rd_data),
    .regs      (regs)
  );

  periph_spi_mux u_mux (
    .periph_sel  (regs.periph_sel),
    .ss2_n       (ss2_n),
    .spi_in      (spi_in),
    .bank_miso   (bank_miso),
    .periph_miso (periph_miso),
    .periph      (periph),
    .miso        (miso)
  );

  // register fields out to the board
  assign led     = regs.led;
  assign oe_4094 = regs.oe_4094;
  assign adc_ctl = regs.adc;

endmodule

/* logic/spi_frame_rx.sv */
//////////////////////////////
// host SPI mode 0 receiver, oversampled on cs
// builds 16 bit frames, shifts read data back on miso
// and passes finished frames to the bank by req/ack
//////////////////////////////

module spi_frame_rx
  import spi_bank_pkg::*;
(
  input  logic       cs,
  input  logic       rst_n,
  input  spi_pins_t  spi_in,
  input  logic [7:0] rd_data,
  input  logic       frame_ack,
  output logic [7:0] rd_addr,
  output frame_t     frame,
  output logic       frame_req,
  output logic       bank_miso
);

  // two flop synchronizer plus one delay stage for edges
  spi_pins_t pin_s1;
  spi_pins_t pin_s2;
  spi_pins_t pin_d;

  // registered edge pulses, 3 cycles behind the pins
  logic sclk_rise;
  logic sclk_fall;
  logic ss_rise;

  // frame assembly
  logic [4:0]            bit_cnt;
  logic [FRAME_BITS-1:0] rx_sr;
  logic [7:0]            addr_q;
  logic [7:0]            tx_sr;
  logic                  frame_done;

  //////////////////////////////
  // pin sync and edge detect
  //////////////////////////////

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      // idle bus, ss_n high
      pin_s1.sclk <= 1'b0;
      pin_s1.ss_n <= 1'b1;
      pin_s1.mosi <= 1'b0;
      pin_s2.sclk <= 1'b0;
      pin_s2.ss_n <= 1'b1;
      pin_s2.mosi <= 1'b0;
      pin_d.sclk  <= 1'b0;
      pin_d.ss_n  <= 1'b1;
      pin_d.mosi  <= 1'b0;
      sclk_rise   <= 1'b0;
      sclk_fall   <= 1'b0;
      ss_rise     <= 1'b0;
    end
    else
    begin
      pin_s1 <= spi_in;
      pin_s2 <= pin_s1;
      pin_d  <= pin_s2;
      // pulses line up with pin_d on the following cycle
      sclk_rise <= pin_s2.sclk & ~pin_d.sclk;
      sclk_fall <= ~pin_s2.sclk & pin_d.sclk;
      ss_rise   <= pin_s2.ss_n & ~pin_d.ss_n;
    end
  end

  //////////////////////////////
  // bit count and shift registers
  //////////////////////////////

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bit_cnt   <= '0;
      rx_sr     <= '0;
      addr_q    <= '0;
      tx_sr     <= '0;
      bank_miso <= 1'b0;
    end
    else if (pin_d.ss_n)
    begin
      // deselected, hold everything clear
      bit_cnt   <= '0;
      rx_sr     <= '0;
      addr_q    <= '0;
      tx_sr     <= '0;
      bank_miso <= 1'b0;
    end
    else
    begin
      if (sclk_rise)
      begin
        // msb first, mosi taken from the same sample as the edge
        rx_sr <= {rx_sr[FRAME_BITS-2:0], pin_d.mosi};
        // saturate so an overlong frame never wraps to a valid count
        if (bit_cnt != 5'd31)
          bit_cnt <= bit_cnt + 5'd1;
        // eighth bit completes the address byte
        if (bit_cnt == 5'd7)
          addr_q <= {rx_sr[6:0], pin_d.mosi};
      end
      if (sclk_fall)
      begin
        if (bit_cnt == 5'd8)
        begin
          // first fall after the address, load read data
          bank_miso <= rd_data[7];
          tx_sr     <= {rd_data[6:0], 1'b0};
        end
        else
        begin
          bank_miso <= tx_sr[7];
          tx_sr     <= {tx_sr[6:0], 1'b0};
        end
      end
    end
  end

  assign rd_addr = addr_q;

  // only exact length frames are handed on
  assign frame_done = ss_rise && (bit_cnt == 5'(FRAME_BITS));

  //////////////////////////////
  // request side of the handshake
  //////////////////////////////

  always_ff @(posedge cs or negedge rst_n)
  begin
    if (!rst_n)
      frame_req <= 1'b0;
    else if (frame_done)
      frame_req <= 1'b1;
    else if (frame_ack)
      frame_req <= 1'b0;
  end

  // frame payload, held until the next complete frame
  always_ff @(posedge cs)
  begin
    if (frame_done)
      frame <= frame_t'(rx_sr);
  end

  // bank must finish the previous frame before the next one lands
  assert property (@(posedge cs) disable iff (!rst_n)
    frame_done |-> !frame_req)
    else $error("frame completed while previous request still pending");

endmodule

/* sim/spi_bank_tb.sv */
//////////////////////////////
// testbench for the SPI control register subsystem
// host frames and peripheral routing run from a table
// results compared with a reference register model
//////////////////////////////

module spi_bank_tb
  import spi_bank_pkg::*;
();

  // host write, read back, frame cut short, peripheral routing
  typedef enum logic [1:0] {M_HOST, M_READ, M_SHORT, M_ROUTE} row_mode_t;

  typedef struct packed {
    logic [79:0] name;
    row_mode_t   mode;
    logic [7:0]  addr;
    logic [7:0]  data;
  } row_t;

  // DUT pins
  logic        cs;
  logic        rst_n;
  spi_pins_t   spi_in;
  logic        ss2_n;
  logic [7:0]  periph_miso;
  logic        miso;
  periph_bus_t periph;
  logic [3:0]  led;
  logic [3:0]  oe_4094;
  logic [3:0]  adc_ctl;

  // reference copy of the register bank
  logic [3:0] m_led;
  logic [7:0] m_sel;
  logic [3:0] m_oe;
  logic [3:0] m_adc;

  row_t   rows[$];
  integer seed = 32'h4478_2144;
  int     n_checks = 0;
  int     n_errors = 0;
  int     cycle_cnt = 0;
  int     cycle_limit = 0;
  logic   table_ready = 1'b0;

  spi_bank_top UUT (.*);

  initial
  begin
    cs = 1'b0;
    forever #4 cs = ~cs;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // low nibble sets, high nibble clears, overlapping bits toggle
  function automatic logic [3:0] set_clear_result(input logic [3:0] cur, input logic [7:0] data);
    logic [3:0] overlap;
    overlap = data[3:0] & data[7:4];
    if (overlap != 4'b0000)
      return cur ^ overlap;
    return (cur & ~data[7:4]) | data[3:0];
  endfunction

  task automatic track_write(input logic [7:0] addr, input logic [7:0] data);
    case (addr)
      ADDR_LED:        m_led = set_clear_result(m_led, data);
      ADDR_PERIPH_SEL: m_sel = data;
      ADDR_OE_4094:    m_oe = set_clear_result(m_oe, data);
      ADDR_ADC:        m_adc = set_clear_result(m_adc, data);
      ADDR_SOFT_RESET:
      begin
        m_led = 4'h0;
        m_sel = 8'h00;
        m_oe  = 4'h0;
        m_adc = 4'h0;
      end
      // oe and routing survive power-up
      ADDR_POWERUP:
      begin
        m_led = 4'h0;
        m_adc = 4'h0;
      end
      default:
      begin
      end
    endcase
  endtask

  function automatic logic [7:0] expected_read(input logic [7:0] addr);
    if (addr == ADDR_LED)
      return {4'h0, m_led};
    if (addr == ADDR_PERIPH_SEL)
      return m_sel;
    if (addr == ADDR_OE_4094)
      return {4'h0, m_oe};
    if (addr == ADDR_ADC)
      return {4'h0, m_adc};
    return 8'h00;
  endfunction

  //////////////////////////////
  // drivers and checks
  //////////////////////////////

  // one time unit past the next rising edge
  task automatic next_cycle();
    @(posedge cs);
    #1;
  endtask

  task automatic compare_byte(input logic [79:0] tname, input string what,
                              input logic [7:0] exp, input logic [7:0] act);
    n_checks++;
    assert (act === exp)
    else
    begin
      n_errors++;
      $display("[FAIL] %0s %0s: expected %h, actual %h", tname, what, exp, act);
    end
  endtask

  // mode 0 frame with sclk 4 cycles low then 4 high and miso read mid high phase
  task automatic send_frame(input logic [7:0] addr, input logic [7:0] data, input int nbits,
                            output logic [7:0] rd_byte);
    logic [15:0] word;
    int          i;
    word    = {addr, data};
    rd_byte = 8'h00;
    next_cycle();
    spi_in.ss_n = 1'b0;
    for (i = 0; i < nbits; i++)
    begin
      spi_in.sclk = 1'b0;
      spi_in.mosi = word[15-i];
      repeat (4) next_cycle();
      spi_in.sclk = 1'b1;
      repeat (2) next_cycle();
      // second byte carries the register
      if (i >= 8)
        rd_byte = {rd_byte[6:0], miso};
      repeat (2) next_cycle();
    end
    spi_in.sclk = 1'b0;
    spi_in.mosi = 1'b0;
    repeat (4) next_cycle();
    spi_in.ss_n = 1'b1;
    // idle gap well past the register update latency
    repeat (16) next_cycle();
  endtask

  task automatic audit_ports(input logic [79:0] tname);
    logic [7:0] line;
    logic [7:0] exp_ss;
    logic       exp_miso;
    int         i;
    line     = 8'h00;
    exp_miso = 1'b0;
    if (!ss2_n && m_sel >= 8'd1 && m_sel <= 8'd8)
    begin
      line[m_sel-8'd1] = 1'b1;
      exp_miso = periph_miso[m_sel-8'd1];
    end
    // strobe ports idle low, normal ports idle high
    for (i = 0; i < 8; i++)
      exp_ss[i] = PERIPH_CS_POL[i] ? line[i] : ~line[i];
    compare_byte(tname, "periph ss", exp_ss, periph.ss);
    compare_byte(tname, "periph sclk", spi_in.sclk ? line : 8'h00, periph.sclk);
    compare_byte(tname, "periph mosi", spi_in.mosi ? line : 8'h00, periph.mosi);
    compare_byte(tname, "miso", {7'd0, exp_miso}, {7'd0, miso});
  endtask

  // walk sclk and mosi with ss2_n low and random peripheral miso
  task automatic exercise_routing(input logic [79:0] tname);
    int k;
    int rnd;
    ss2_n = 1'b0;
    for (k = 0; k < 4; k++)
    begin
      spi_in.sclk = k[0];
      spi_in.mosi = k[1];
      rnd = $random(seed);
      periph_miso = rnd[7:0];
      next_cycle();
      audit_ports(tname);
    end
    ss2_n       = 1'b1;
    spi_in.sclk = 1'b0;
    spi_in.mosi = 1'b0;
    periph_miso = 8'h00;
    next_cycle();
  endtask

  task automatic regs_vs_model(input logic [79:0] tname);
    compare_byte(tname, "led", {4'h0, m_led}, {4'h0, led});
    compare_byte(tname, "oe_4094", {4'h0, m_oe}, {4'h0, oe_4094});
    compare_byte(tname, "adc_ctl", {4'h0, m_adc}, {4'h0, adc_ctl});
    audit_ports(tname);
  endtask

  task automatic add_row(input logic [79:0] name, input row_mode_t mode,
                         input logic [7:0] addr, input logic [7:0] data);
    row_t r;
    r.name = name;
    r.mode = mode;
    r.addr = addr;
    r.data = data;
    rows.push_back(r);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    row_t       row;
    logic [7:0] wdata;
    logic [7:0] exp_rd;
    logic [7:0] got_rd;
    int         nbits;
    int         r;
    rst_n       = 1'b0;
    spi_in.sclk = 1'b0;
    spi_in.ss_n = 1'b1;
    spi_in.mosi = 1'b0;
    ss2_n       = 1'b1;
    periph_miso = 8'h00;
    m_led = LED_RESET;
    m_sel = 8'h00;
    m_oe  = 4'h0;
    m_adc = 4'h0;
    // each write is read back by the next frame to the same address
    add_row("led set", M_HOST, ADDR_LED, 8'h06);
    add_row("led clr", M_HOST, ADDR_LED, 8'h30);
    add_row("led tog", M_HOST, ADDR_LED, 8'h55);
    add_row("led rd", M_READ, ADDR_LED, 8'h00);
    add_row("oe set", M_HOST, ADDR_OE_4094, 8'h0f);
    add_row("oe tog", M_HOST, ADDR_OE_4094, 8'h99);
    add_row("oe rd", M_READ, ADDR_OE_4094, 8'h00);
    add_row("adc set", M_HOST, ADDR_ADC, 8'h0b);
    add_row("adc mix", M_HOST, ADDR_ADC, 8'h62);
    add_row("adc rd", M_READ, ADDR_ADC, 8'h00);
    // first 12 bits of 0x70f0 leave led address and all set bits in the shift register
    add_row("short led", M_SHORT, 8'h70, 8'hf0);
    add_row("sel 3", M_ROUTE, ADDR_PERIPH_SEL, 8'd3);
    add_row("sel 5", M_ROUTE, ADDR_PERIPH_SEL, 8'd5);
    add_row("sel 8", M_ROUTE, ADDR_PERIPH_SEL, 8'd8);
    add_row("sel 0", M_ROUTE, ADDR_PERIPH_SEL, 8'd0);
    add_row("sel 1", M_ROUTE, ADDR_PERIPH_SEL, 8'd1);
    add_row("powerup", M_HOST, ADDR_POWERUP, 8'h00);
    add_row("sel rd", M_READ, ADDR_PERIPH_SEL, 8'h00);
    add_row("oe rd2", M_READ, ADDR_OE_4094, 8'h00);
    add_row("sel 6", M_ROUTE, ADDR_PERIPH_SEL, 8'd6);
    add_row("soft rst", M_HOST, ADDR_SOFT_RESET, 8'h00);
    add_row("sel rd2", M_READ, ADDR_PERIPH_SEL, 8'h00);
    add_row("led rd2", M_READ, ADDR_LED, 8'h00);
    add_row("unknown", M_HOST, 8'h20, 8'hff);
    cycle_limit = rows.size() * 160 + 200;
    table_ready = 1'b1;
    repeat (3) @(posedge cs);
    #1;
    rst_n = 1'b1;
    next_cycle();
    regs_vs_model("reset");
    for (r = 0; r < rows.size(); r++)
    begin
      row   = rows[r];
      wdata = row.data;
      nbits = (row.mode == M_SHORT) ? 12 : 16;
      // read frames write back a value that changes nothing
      if (row.mode == M_READ)
        wdata = (row.addr == ADDR_PERIPH_SEL) ? m_sel : 8'h00;
      exp_rd = expected_read(row.addr);
      send_frame(row.addr, wdata, nbits, got_rd);
      if (nbits == 16)
      begin
        compare_byte(row.name, "read byte", exp_rd, got_rd);
        track_write(row.addr, wdata);
      end
      if (row.mode == M_ROUTE)
        exercise_routing(row.name);
      regs_vs_model(row.name);
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

  // cycle budget scaled by the table length
  initial
  begin
    wait (table_ready);
    while (cycle_cnt < cycle_limit)
    begin
      @(posedge cs);
      cycle_cnt++;
    end
    n_errors++;
    $display("timeout: run still going after %0d cycles", cycle_limit);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* spi_bank_top.f */
logic/spi_bank_pkg.sv
logic/spi_frame_rx.sv
logic/reg_bank.sv
logic/periph_spi_mux.sv
logic/spi_bank_top.sv
sim/spi_bank_tb.sv
